//--- cdb.f
+incdir+src
src/cdb_pkg.sv
src/result_queue.sv
src/cdb_arbiter.sv
src/cdb_broadcast.sv
src/cdb.sv
bench/cdb_properties.sv
bench/cdb_tb.sv

//--- Makefile
SOURCES := $(wildcard src/*.sv src/*.svh bench/*.sv)

run: obj_dir/Vcdb_tb
	./obj_dir/Vcdb_tb | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

obj_dir/Vcdb_tb: $(SOURCES) cdb.f
	verilator --binary --timing --assert --top-module cdb_tb -f cdb.f -o Vcdb_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- bench/cdb_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdb_consts.svh"

module cdb_tb
    import cdb_pkg::*;
();

    logic                    clock;
    logic                    rst_n;
    logic                    commit_mis_pred;
    logic                    alu_valid;
    logic                    mul_valid;
    logic                    load_valid;
    logic                    br_valid;
    exec_result_t            alu_result;
    exec_result_t            mul_result;
    exec_result_t            load_result;
    br_result_t              br_result;
    logic                    alu_full;
    logic                    mul_full;
    logic                    load_full;
    logic                    br_full;
    logic [`NUM_SOURCES-1:0] source_select;
    cdb_packet_t             cdb_out;

    integer                  seed;
    int                      fire_pct;
    logic                    flush_req;
    logic                    running;

    // reference model state
    br_result_t              model_q [`NUM_SOURCES][$];
    int                      depth [`NUM_SOURCES];
    string                   src_name [`NUM_SOURCES];
    int                      model_ptr;
    cdb_packet_t             exp_bus;
    logic [`NUM_SOURCES-1:0] saw_full;

    int                      error_count;
    int                      check_count;
    int                      test_count;
    int                      test_errors;
    int                      n_pushed;
    int                      n_dropped;
    int                      n_delivered;
    int                      wait_cycles;

    cdb u_dut (
        .clock           (clock),
        .rst_n           (rst_n),
        .commit_mis_pred (commit_mis_pred),
        .alu_valid       (alu_valid),
        .alu_result      (alu_result),
        .alu_full        (alu_full),
        .mul_valid       (mul_valid),
        .mul_result      (mul_result),
        .mul_full        (mul_full),
        .load_valid      (load_valid),
        .load_result     (load_result),
        .load_full       (load_full),
        .br_valid        (br_valid),
        .br_result       (br_result),
        .br_full         (br_full),
        .source_select   (source_select),
        .cdb_out         (cdb_out)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic fires(input int pct);
        logic [31:0] r;
        r = $random(seed);
        fires = (r % 100) < pct;
    endfunction

    function automatic logic [127:0] random_bits();
        random_bits = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic logic model_idle();
        model_idle = !exp_bus.valid;
        for (int i = 0; i < `NUM_SOURCES; i++) begin
            if (model_q[i].size() != 0) model_idle = 1'b0;
        end
    endfunction

    task automatic start_test();
        test_errors = error_count;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("test %s done with %0d errors", name, error_count - test_errors);
    endtask

    // producers, never firing into a queue that will be full after this edge
    always @(posedge clock) begin
        logic [127:0] bits;
        commit_mis_pred <= flush_req;
        alu_valid  <= running && (model_q[SRC_ALU].size() < depth[SRC_ALU]) && fires(fire_pct);
        mul_valid  <= running && (model_q[SRC_MUL].size() < depth[SRC_MUL]) && fires(fire_pct);
        load_valid <= running && (model_q[SRC_LOAD].size() < depth[SRC_LOAD])
                      && fires(fire_pct);
        br_valid   <= running && (model_q[SRC_BR].size() < depth[SRC_BR]) && fires(fire_pct);
        bits = random_bits();
        alu_result <= bits[$bits(exec_result_t)-1:0];
        bits = random_bits();
        mul_result <= bits[$bits(exec_result_t)-1:0];
        bits = random_bits();
        load_result <= bits[$bits(exec_result_t)-1:0];
        bits = random_bits();
        br_result <= bits[$bits(br_result_t)-1:0];
    end

    // model and checks, sampled mid-cycle where everything is stable
    always @(negedge clock) begin
        int                      g;
        int                      idx;
        logic                    was_empty;
        logic                    exp_full;
        logic [`NUM_SOURCES-1:0] in_valid;
        logic [`NUM_SOURCES-1:0] full_now;
        logic [`NUM_SOURCES-1:0] want_grant;
        br_result_t              in_data [`NUM_SOURCES];
        br_result_t              head;
        in_valid = {br_valid, load_valid, mul_valid, alu_valid};
        full_now = {br_full, load_full, mul_full, alu_full};
        in_data[SRC_ALU].result  = alu_result;
        in_data[SRC_ALU].branch  = '0;
        in_data[SRC_MUL].result  = mul_result;
        in_data[SRC_MUL].branch  = '0;
        in_data[SRC_LOAD].result = load_result;
        in_data[SRC_LOAD].branch = '0;
        in_data[SRC_BR]          = br_result;
        head = '0;
        if (!rst_n) begin
            for (int i = 0; i < `NUM_SOURCES; i++) model_q[i].delete();
            model_ptr = 0;
            exp_bus   = '0;
        end else begin
            check_count++;
            assert (cdb_out == exp_bus) else begin
                $display("error at %0t: cdb_out expected %h got %h", $time, exp_bus, cdb_out);
                error_count++;
            end
            if (cdb_out.valid) n_delivered++;
            for (int i = 0; i < `NUM_SOURCES; i++) begin
                exp_full = (model_q[i].size() == depth[i]);
                if (full_now[i]) saw_full[i] = 1'b1;
                check_count++;
                assert (full_now[i] == exp_full) else begin
                    $display("error at %0t: %s_full expected %0b got %0b",
                             $time, src_name[i], exp_full, full_now[i]);
                    error_count++;
                end
            end
            // first requester at or after the pointer wins
            g = -1;
            want_grant = '0;
            for (int k = 0; k < `NUM_SOURCES; k++) begin
                idx = (model_ptr + k) % `NUM_SOURCES;
                if (g < 0 && (model_q[idx].size() > 0 || in_valid[idx])) g = idx;
            end
            if (g >= 0) want_grant[g] = 1'b1;
            check_count++;
            assert (source_select == want_grant) else begin
                $display("error at %0t: source_select expected %b got %b",
                         $time, want_grant, source_select);
                error_count++;
            end
            if (g >= 0) head = (model_q[g].size() > 0) ? model_q[g][0] : in_data[g];
            n_pushed += $countones(in_valid);
            if (commit_mis_pred) begin
                for (int i = 0; i < `NUM_SOURCES; i++) begin
                    n_dropped += model_q[i].size() + int'(in_valid[i]);
                    model_q[i].delete();
                end
                model_ptr = 0;
                exp_bus   = '0;
            end else begin
                for (int i = 0; i < `NUM_SOURCES; i++) begin
                    was_empty = (model_q[i].size() == 0);
                    if (i == g && !was_empty) void'(model_q[i].pop_front());
                    if (in_valid[i] && !(was_empty && i == g)) model_q[i].push_back(in_data[i]);
                end
                exp_bus = '0;
                if (g >= 0) begin
                    exp_bus.valid  = 1'b1;
                    exp_bus.result = head.result;
                    if (g == SRC_BR) exp_bus.branch = head.branch;
                    model_ptr = (g + 1) % `NUM_SOURCES;
                end
            end
        end
    end

    initial begin
        seed            = 32'h92cf_51ee;
        rst_n           = 1'b0;
        commit_mis_pred = 1'b0;
        alu_valid       = 1'b0;
        mul_valid       = 1'b0;
        load_valid      = 1'b0;
        br_valid        = 1'b0;
        alu_result      = '0;
        mul_result      = '0;
        load_result     = '0;
        br_result       = '0;
        running         = 1'b0;
        fire_pct        = 0;
        flush_req       = 1'b0;
        exp_bus         = '0;
        model_ptr       = 0;
        saw_full        = '0;
        error_count     = 0;
        check_count     = 0;
        test_count      = 0;
        n_pushed        = 0;
        n_dropped       = 0;
        n_delivered     = 0;
        depth[SRC_ALU]  = `ALU_QUEUE_DEPTH;
        depth[SRC_MUL]  = `MUL_QUEUE_DEPTH;
        depth[SRC_LOAD] = `LOAD_QUEUE_DEPTH;
        depth[SRC_BR]   = `BR_QUEUE_DEPTH;
        src_name[SRC_ALU]  = "alu";
        src_name[SRC_MUL]  = "mul";
        src_name[SRC_LOAD] = "load";
        src_name[SRC_BR]   = "br";

        repeat (3) @(posedge clock);
        rst_n   <= 1'b1;
        running <= 1'b1;

        start_test();
        fire_pct <= 50;
        repeat (300) @(posedge clock);
        finish_test("random_traffic");

        // mostly empty queues, so bypass wins dominate
        start_test();
        fire_pct <= 15;
        repeat (200) @(posedge clock);
        finish_test("sparse_bypass");

        start_test();
        saw_full = '0;
        fire_pct <= 100;
        repeat (60) @(posedge clock);
        check_count++;
        assert (saw_full == '1) else begin
            $display("full level never rose on every queue, seen %b", saw_full);
            error_count++;
        end
        finish_test("saturating_burst");

        start_test();
        repeat (12) @(posedge clock);
        flush_req <= 1'b1;
        @(posedge clock);
        flush_req <= 1'b0;
        fire_pct <= 60;
        repeat (150) @(posedge clock);
        finish_test("flush_mid_burst");

        start_test();
        fire_pct <= 0;
        wait_cycles = 0;
        @(posedge clock);
        while (!model_idle() && wait_cycles < 100) begin
            @(posedge clock);
            wait_cycles++;
        end
        if (!model_idle()) begin
            $display("timeout: results did not drain from the queues");
            $display("Finished with errors");
            $finish;
        end else begin
            check_count++;
            assert (n_pushed - n_dropped == n_delivered) else begin
                $display("error at %0t: delivered count expected %0d got %0d",
                         $time, n_pushed - n_dropped, n_delivered);
                error_count++;
            end
            finish_test("drain_and_count");
            $display("tests: %0d, checks: %0d, errors: %0d",
                     test_count, check_count, error_count);
            if (error_count == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/cdb_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdb_consts.svh"

module cdb_properties
    import cdb_pkg::*;
(
    input logic                    clock,
    input logic                    rst_n,
    input logic                    commit_mis_pred,
    input logic                    alu_valid,
    input logic                    mul_valid,
    input logic                    load_valid,
    input logic                    br_valid,
    input logic                    alu_full,
    input logic                    mul_full,
    input logic                    load_full,
    input logic                    br_full,
    input logic [`NUM_SOURCES-1:0] source_select,
    input cdb_packet_t             cdb_out
);

    // back-pressure from each queue
    alu_no_push_full: assert property (@(posedge clock) disable iff (!rst_n)
        alu_valid |-> !alu_full) else $error("alu result pushed into a full queue");

    mul_no_push_full: assert property (@(posedge clock) disable iff (!rst_n)
        mul_valid |-> !mul_full) else $error("mul result pushed into a full queue");

    load_no_push_full: assert property (@(posedge clock) disable iff (!rst_n)
        load_valid |-> !load_full) else $error("load result pushed into a full queue");

    br_no_push_full: assert property (@(posedge clock) disable iff (!rst_n)
        br_valid |-> !br_full) else $error("branch result pushed into a full queue");

    grant_onehot: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(source_select)) else $error("grant has more than one bit set");

    bus_cleared_after_flush: assert property (@(posedge clock) disable iff (!rst_n)
        commit_mis_pred |=> !cdb_out.valid) else $error("bus still valid after a flush");

    // only the branch unit may put resolution fields on the bus
    branch_fields_zero: assert property (@(posedge clock) disable iff (!rst_n)
        !source_select[SRC_BR] |=> (cdb_out.branch == '0))
        else $error("branch fields set for a non-branch source");

endmodule

bind cdb cdb_properties u_properties (
    .clock           (clock),
    .rst_n           (rst_n),
    .commit_mis_pred (commit_mis_pred),
    .alu_valid       (alu_valid),
    .mul_valid       (mul_valid),
    .load_valid      (load_valid),
    .br_valid        (br_valid),
    .alu_full        (alu_full),
    .mul_full        (mul_full),
    .load_full       (load_full),
    .br_full         (br_full),
    .source_select   (source_select),
    .cdb_out         (cdb_out)
);

`default_nettype wire

//--- src/cdb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdb_consts.svh"

module cdb
    import cdb_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    commit_mis_pred,

    input  logic                    alu_valid,
    input  exec_result_t            alu_result,
    output logic                    alu_full,

    input  logic                    mul_valid,
    input  exec_result_t            mul_result,
    output logic                    mul_full,

    input  logic                    load_valid,
    input  exec_result_t            load_result,
    output logic                    load_full,

    input  logic                    br_valid,
    input  br_result_t              br_result,
    output logic                    br_full,

    output logic [`NUM_SOURCES-1:0] source_select,
    output cdb_packet_t             cdb_out
);

    logic         alu_head_valid;
    logic         mul_head_valid;
    logic         load_head_valid;
    logic         br_head_valid;

    exec_result_t alu_head;
    exec_result_t mul_head;
    exec_result_t load_head;
    br_result_t   br_head;

    result_queue #(.DEPTH(`ALU_QUEUE_DEPTH), .entry_t(exec_result_t)) u_alu_queue (
        .clock      (clock),
        .rst_n      (rst_n),
        .flush      (commit_mis_pred),
        .push       (alu_valid),
        .push_data  (alu_result),
        .pop        (source_select[SRC_ALU]),
        .head_valid (alu_head_valid),
        .head_data  (alu_head),
        .full       (alu_full)
    );

    result_queue #(.DEPTH(`MUL_QUEUE_DEPTH), .entry_t(exec_result_t)) u_mul_queue (
        .clock      (clock),
        .rst_n      (rst_n),
        .flush      (commit_mis_pred),
        .push       (mul_valid),
        .push_data  (mul_result),
        .pop        (source_select[SRC_MUL]),
        .head_valid (mul_head_valid),
        .head_data  (mul_head),
        .full       (mul_full)
    );

    result_queue #(.DEPTH(`LOAD_QUEUE_DEPTH), .entry_t(exec_result_t)) u_load_queue (
        .clock      (clock),
        .rst_n      (rst_n),
        .flush      (commit_mis_pred),
        .push       (load_valid),
        .push_data  (load_result),
        .pop        (source_select[SRC_LOAD]),
        .head_valid (load_head_valid),
        .head_data  (load_head),
        .full       (load_full)
    );

    // branch entries carry the resolution fields along
    result_queue #(.DEPTH(`BR_QUEUE_DEPTH), .entry_t(br_result_t)) u_br_queue (
        .clock      (clock),
        .rst_n      (rst_n),
        .flush      (commit_mis_pred),
        .push       (br_valid),
        .push_data  (br_result),
        .pop        (source_select[SRC_BR]),
        .head_valid (br_head_valid),
        .head_data  (br_head),
        .full       (br_full)
    );

    // request bit order follows source_e
    cdb_arbiter u_arbiter (
        .clock   (clock),
        .rst_n   (rst_n),
        .flush   (commit_mis_pred),
        .request ({br_head_valid, load_head_valid, mul_head_valid, alu_head_valid}),
        .grant   (source_select)
    );

    cdb_broadcast u_broadcast (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (commit_mis_pred),
        .grant     (source_select),
        .alu_head  (alu_head),
        .mul_head  (mul_head),
        .load_head (load_head),
        .br_head   (br_head),
        .cdb_out   (cdb_out)
    );

endmodule

`default_nettype wire

//--- src/cdb_broadcast.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdb_consts.svh"

module cdb_broadcast
    import cdb_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic [`NUM_SOURCES-1:0] grant,
    input  exec_result_t            alu_head,
    input  exec_result_t            mul_head,
    input  exec_result_t            load_head,
    input  br_result_t              br_head,
    output cdb_packet_t             cdb_out
);

    cdb_packet_t next_pkt;

    // grant is one-hot, so chain order does not matter
    always_comb begin
        next_pkt = '0;
        if (grant[SRC_ALU]) begin
            next_pkt.valid  = 1'b1;
            next_pkt.result = alu_head;
        end else if (grant[SRC_MUL]) begin
            next_pkt.valid  = 1'b1;
            next_pkt.result = mul_head;
        end else if (grant[SRC_LOAD]) begin
            next_pkt.valid  = 1'b1;
            next_pkt.result = load_head;
        end else if (grant[SRC_BR]) begin
            next_pkt.valid  = 1'b1;
            next_pkt.result = br_head.result;
            // only the branch unit fills these
            next_pkt.branch = br_head.branch;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            cdb_out <= '0;
        end else begin
            cdb_out <= next_pkt;
        end
    end

endmodule

`default_nettype wire

//--- src/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdb_consts.svh"

module cdb_arbiter
    import cdb_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic [`NUM_SOURCES-1:0] request,
    output logic [`NUM_SOURCES-1:0] grant
);

    localparam int IDX_W = $clog2(`NUM_SOURCES);

    // search starts here
    logic [IDX_W-1:0] ptr;
    logic [IDX_W-1:0] grant_idx;
    logic             found;

    always_comb begin
        logic [IDX_W-1:0] idx;
        grant     = '0;
        grant_idx = ptr;
        found     = 1'b0;
        for (int i = 0; i < `NUM_SOURCES; i++) begin
            // wraps naturally at the pointer width
            idx = ptr + IDX_W'(i);
            if (!found && request[idx]) begin
                grant[idx] = 1'b1;
                grant_idx  = idx;
                found      = 1'b1;
            end
        end
    end

    // winner drops to lowest priority next cycle
    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            ptr <= SRC_ALU;
        end else if (found) begin
            ptr <= grant_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/result_queue.sv
`timescale 1ns/1ps
`default_nettype none

module result_queue #(
    parameter int  DEPTH   = 4,
    parameter type entry_t = logic
) (
    input  logic   clock,
    input  logic   rst_n,
    input  logic   flush,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output logic   head_valid,
    output entry_t head_data,
    output logic   full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t             mem [DEPTH];
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [CNT_W-1:0]   count;
    logic               empty;
    logic               write_en;
    logic               read_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // empty queue shows the arriving entry directly
    assign head_valid = !empty || push;
    assign head_data  = empty ? push_data : mem[head];

    // a bypassed entry that is popped right away never lands in storage
    assign write_en = push && !(empty && pop);
    assign read_en  = pop && !empty;

    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[tail] <= push_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (write_en) begin
                tail <= next_ptr(tail);
            end
            if (read_en) begin
                head <= next_ptr(head);
            end
            case ({write_en, read_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/cdb_pkg.sv
`default_nettype none

`include "cdb_consts.svh"

package cdb_pkg;

    // one result from any execution unit, 75 bits
    typedef struct packed {
        logic [`XLEN-1:0]    value;
        logic [`PRF_LEN-1:0] dest_preg;
        logic [`ROB_LEN-1:0] rob_idx;
        logic [`XLEN-1:0]    pc;
    } exec_result_t;

    // branch resolution, 36 bits
    typedef struct packed {
        logic             direction;
        logic [`XLEN-1:0] target_pc;
        logic             mis_pred;
        logic             local_pred;
        logic             global_pred;
    } branch_info_t;

    // what the branch unit hands in
    typedef struct packed {
        exec_result_t result;
        branch_info_t branch;
    } br_result_t;

    // the bus word
    typedef struct packed {
        logic         valid;
        exec_result_t result;
        branch_info_t branch;
    } cdb_packet_t;

    // bit positions in request and grant
    typedef enum logic [1:0] {
        SRC_ALU  = 2'd0,
        SRC_MUL  = 2'd1,
        SRC_LOAD = 2'd2,
        SRC_BR   = 2'd3
    } source_e;

endpackage

`default_nettype wire

//--- src/cdb_consts.svh
`ifndef CDB_CONSTS_SVH
`define CDB_CONSTS_SVH

// data and pc width
`define XLEN 32

// physical register index width
`define PRF_LEN 6

// reorder buffer index width
`define ROB_LEN 5

// per-source result queue depths
`define ALU_QUEUE_DEPTH  4
`define MUL_QUEUE_DEPTH  2
`define LOAD_QUEUE_DEPTH 4
`define BR_QUEUE_DEPTH   4

// alu, mul, load, branch
`define NUM_SOURCES 4

`endif
